// File: Bender.yml
package:
  name: soc_top

sources:
  - files:
      - source/soc_pkg.sv
      - source/apb_xbar.sv
      - source/main_memory.sv
      - source/plic_lite.sv
      - source/soc_top.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/tb_soc_top.sv

// File: bench/tb_apb_tasks.svh
// apb master write and read tasks, access phase wait with timeout, value check

// runs the access phase until pready, returns the number of access cycles
task automatic wait_ready(output data_t rdata, output logic err, output int cycles);
    logic done;
    done   = 1'b0;
    cycles = 0;
    while (!done) begin
        cycles++;
        @(negedge clk_i);   // mid cycle, response settled
        if (pready_o) begin
            rdata = prdata_o;
            err   = pslverr_o;
            done  = 1'b1;
        end else if (cycles >= ACC_TIMEOUT) begin
            abort_run("pready_o never rose within the access timeout");
        end
        @(posedge clk_i);
        #DRV_DLY;
    end
    psel_i    = 1'b0;   // back to idle after the completing edge
    penable_i = 1'b0;
endtask

task automatic apb_write(input addr_t addr, input data_t data, input strb_t strb,
                         output logic err, output int cycles);
    data_t unused;
    @(posedge clk_i);
    #DRV_DLY;
    psel_i    = 1'b1;   // setup phase
    penable_i = 1'b0;
    pwrite_i  = 1'b1;
    paddr_i   = addr;
    pwdata_i  = data;
    pstrb_i   = strb;
    @(posedge clk_i);
    #DRV_DLY;
    penable_i = 1'b1;
    wait_ready(unused, err, cycles);
endtask

task automatic apb_read(input addr_t addr, output data_t data, output logic err,
                        output int cycles);
    @(posedge clk_i);
    #DRV_DLY;
    psel_i    = 1'b1;
    penable_i = 1'b0;
    pwrite_i  = 1'b0;
    paddr_i   = addr;
    pstrb_i   = '0;   // no strobes on reads
    @(posedge clk_i);
    #DRV_DLY;
    penable_i = 1'b1;
    wait_ready(data, err, cycles);
endtask

// compare one value, report and count a mismatch
task automatic check_value(input string name, input data_t exp, input data_t act);
    assert (act === exp) else begin
        $display("ERR %0t %s expected %h got %h", $time, name, exp, act);
        err_count++;
    end
endtask

// File: bench/tb_soc_top.sv
// soc_top testbench with clock, reset, apb stimulus, reference models, assertions and report

`timescale 1ns/10ps

module tb_soc_top import soc_pkg::*; ();

    localparam int unsigned MEM_WORDS   = 256;
    localparam int unsigned NUM_SRC     = 8;
    localparam int          ACC_TIMEOUT = 16;           // access cycles before giving up
    localparam int          DRV_DLY     = 2;            // ns after the rising edge
    localparam int unsigned SEED        = 32'h7e60_2fbe;

    logic               clk_i;
    logic               arst_n_i;
    logic               psel_i;
    logic               penable_i;
    logic               pwrite_i;
    addr_t              paddr_i;
    data_t              pwdata_i;
    strb_t              pstrb_i;
    data_t              prdata_o;
    logic               pready_o;
    logic               pslverr_o;
    logic [NUM_SRC-1:0] irq_src_i;
    logic               irq_o;

    int                 err_count;
    int                 test_errs;    // error count at test start
    int                 pass_count;
    int                 fail_count;
    data_t              mem_model [MEM_WORDS];
    logic [NUM_SRC-1:0] pend_model;
    logic [NUM_SRC-1:0] en_model;

    soc_top #(
        .MEM_WORDS ( MEM_WORDS ),
        .NUM_SRC   ( NUM_SRC   )
    ) dut (
        .clk_i     ( clk_i     ),
        .arst_n_i  ( arst_n_i  ),
        .psel_i    ( psel_i    ),
        .penable_i ( penable_i ),
        .pwrite_i  ( pwrite_i  ),
        .paddr_i   ( paddr_i   ),
        .pwdata_i  ( pwdata_i  ),
        .pstrb_i   ( pstrb_i   ),
        .prdata_o  ( prdata_o  ),
        .pready_o  ( pready_o  ),
        .pslverr_o ( pslverr_o ),
        .irq_src_i ( irq_src_i ),
        .irq_o     ( irq_o     )
    );

    initial clk_i = 1'b0;
    always #20 clk_i = ~clk_i;   // 40 ns period

    task automatic abort_run(input string why);
        $display("%s at %0t", why, $time);
        $display(">>> FAIL");
        $finish;
    endtask

    `include "tb_apb_tasks.svh"

    ////////////////////////////////////////////////////////////
    // reference rules
    ////////////////////////////////////////////////////////////

    // expected decode from the address map
    function automatic slave_sel_e decode_slave(input addr_t addr);
        if (addr >= MEM_BASE && addr < MEM_BASE + addr_t'(MEM_WORDS * STRB_WIDTH)) begin
            return SLV_MEM;
        end
        if (addr >= PLIC_BASE && addr < PLIC_BASE + PLIC_SPAN) begin
            return SLV_PLIC;
        end
        return SLV_NONE;
    endfunction

    // byte lane merge of a strobed write
    function automatic data_t merge_bytes(input data_t old, input data_t wr, input strb_t strb);
        data_t res;
        res = old;
        for (int b = 0; b < STRB_WIDTH; b++) begin
            if (strb[b]) res[8*b +: 8] = wr[8*b +: 8];
        end
        return res;
    endfunction

    function automatic data_t fill_word(input addr_t addr);
        return (addr * 32'h9E37_79B1) ^ {addr[15:0], addr[31:16]};   // all address bits count
    endfunction

    function automatic data_t lowest_id(input logic [NUM_SRC-1:0] bits);
        for (int i = 1; i < NUM_SRC; i++) begin
            if (bits[i]) return data_t'(i);
        end
        return '0;   // nothing to claim
    endfunction

    task automatic note_failure(input string what);
        $display("%s at %0t", what, $time);
        err_count++;
    endtask

    task automatic end_test(input string name);
        if (err_count == test_errs) begin
            pass_count++;
            $display("test %s: passed", name);
        end else begin
            fail_count++;
            $display("test %s: failed with %0d errors", name, err_count - test_errs);
        end
        test_errs = err_count;
    endtask

    ////////////////////////////////////////////////////////////
    // protocol and timing assertions
    ////////////////////////////////////////////////////////////

    assert property (@(posedge clk_i) disable iff (!arst_n_i)
        pslverr_o |-> pready_o)
        else note_failure("pslverr_o high outside a completing cycle");
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
        pready_o |-> psel_i && penable_i)
        else note_failure("pready_o high outside an access phase");
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
        psel_i && !penable_i && pwrite_i && (decode_slave(paddr_i) == SLV_MEM) |=> pready_o)
        else note_failure("memory write missed its first access cycle");
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
        psel_i && !penable_i && !pwrite_i && (decode_slave(paddr_i) == SLV_MEM)
            |=> !pready_o ##1 pready_o)
        else note_failure("memory read did not complete in its second access cycle");
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
        psel_i && !penable_i && (decode_slave(paddr_i) == SLV_PLIC) |=> pready_o)
        else note_failure("plic access missed its first access cycle");
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
        psel_i && !penable_i && (decode_slave(paddr_i) == SLV_NONE)
            |=> pready_o && pslverr_o && (prdata_o == '0))
        else note_failure("unmapped access gave no error response in its first cycle");
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
        psel_i && (decode_slave(paddr_i) == SLV_NONE)
            |-> !dut.mem_psel && !dut.plic_psel)
        else note_failure("a slave was selected for an unmapped address");
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
        pready_o && (decode_slave(paddr_i) == SLV_MEM) |-> !pslverr_o)
        else note_failure("memory answered with an error");

    ////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////

    initial begin
        data_t       rd;
        logic        err;
        int          cyc;
        addr_t       addr;
        data_t       wdata;
        strb_t       strb;
        int unsigned idx;
        int unsigned idx_list [16];
        void'($urandom(SEED));
        {psel_i, penable_i, pwrite_i} = '0;
        paddr_i    = '0;
        pwdata_i   = '0;
        pstrb_i    = '0;
        irq_src_i  = '0;
        arst_n_i   = 1'b0;
        {err_count, test_errs, pass_count, fail_count} = '0;
        pend_model = '0;
        en_model   = '0;
        repeat (3) @(posedge clk_i);
        #DRV_DLY;
        arst_n_i = 1'b1;

        // 1 quiet outputs and clear plic registers after reset
        @(negedge clk_i);
        check_value("pready_o", '0, data_t'(pready_o));
        check_value("pslverr_o", '0, data_t'(pslverr_o));
        check_value("irq_o", '0, data_t'(irq_o));
        check_value("prdata_o", '0, prdata_o);
        apb_read(PLIC_BASE + addr_t'(REG_PENDING), rd, err, cyc);
        check_value("pending", '0, rd);
        apb_read(PLIC_BASE + addr_t'(REG_ENABLE), rd, err, cyc);
        check_value("enable", '0, rd);
        end_test("reset");

        // 2 fill, strobed writes and read back against the model
        for (int i = 0; i < 16; i++) begin
            idx_list[i]    = $urandom_range(MEM_WORDS - 1);
            addr           = MEM_BASE + addr_t'(idx_list[i] * STRB_WIDTH);
            mem_model[idx_list[i]] = fill_word(addr);
            apb_write(addr, fill_word(addr), '1, err, cyc);
            check_value("write access cycles", 1, data_t'(cyc));
        end
        repeat (32) begin
            idx   = idx_list[$urandom_range(15)];
            wdata = $urandom;
            strb  = strb_t'($urandom);
            apb_write(MEM_BASE + addr_t'(idx * STRB_WIDTH), wdata, strb, err, cyc);
            mem_model[idx] = merge_bytes(mem_model[idx], wdata, strb);
            check_value("write access cycles", 1, data_t'(cyc));
        end
        for (int i = 0; i < 16; i++) begin
            apb_read(MEM_BASE + addr_t'(idx_list[i] * STRB_WIDTH), rd, err, cyc);
            check_value("prdata_o", mem_model[idx_list[i]], rd);
            check_value("pslverr_o", '0, data_t'(err));
            check_value("read access cycles", 2, data_t'(cyc));
        end
        end_test("memory");

        // 3 address just past memory that aliases a modelled word in the index bits
        addr = MEM_BASE + addr_t'((MEM_WORDS + idx_list[0]) * STRB_WIDTH);
        apb_write(addr, ~mem_model[idx_list[0]], '1, err, cyc);
        check_value("pslverr_o", 1, data_t'(err));
        check_value("error access cycles", 1, data_t'(cyc));
        apb_read(addr, rd, err, cyc);
        check_value("pslverr_o", 1, data_t'(err));
        check_value("prdata_o", '0, rd);
        apb_read(MEM_BASE + addr_t'(idx_list[0] * STRB_WIDTH), rd, err, cyc);
        check_value("prdata_o", mem_model[idx_list[0]], rd);
        end_test("unmapped");

        // 4 masked sources pend but raise no irq until enabled
        @(posedge clk_i);
        #DRV_DLY;
        irq_src_i  = NUM_SRC'(8'h5B);   // bit 0 included on purpose
        pend_model = pend_model | (irq_src_i & ~NUM_SRC'(1));
        repeat (2) @(posedge clk_i);
        #DRV_DLY;
        irq_src_i = '0;
        @(negedge clk_i);
        check_value("irq_o", '0, data_t'(irq_o));
        apb_read(PLIC_BASE + addr_t'(REG_PENDING), rd, err, cyc);
        check_value("pending", data_t'(pend_model), rd);
        en_model = NUM_SRC'(8'h08);
        apb_write(PLIC_BASE + addr_t'(REG_ENABLE), data_t'(en_model), '1, err, cyc);
        @(negedge clk_i);
        check_value("irq_o", 1, data_t'(irq_o));
        end_test("masked source");

        // 5 claims come out lowest id first
        @(posedge clk_i);
        #DRV_DLY;
        irq_src_i  = NUM_SRC'(8'h84);
        pend_model = pend_model | irq_src_i;
        @(posedge clk_i);
        #DRV_DLY;
        irq_src_i = '0;
        en_model  = ~NUM_SRC'(1);   // source 0 stays reserved
        apb_write(PLIC_BASE + addr_t'(REG_ENABLE), data_t'(en_model), '1, err, cyc);
        for (int n = 0; n < NUM_SRC; n++) begin
            if ((pend_model & en_model) != '0) begin
                apb_read(PLIC_BASE + addr_t'(REG_CLAIM), rd, err, cyc);
                check_value("claim id", lowest_id(pend_model & en_model), rd);
                pend_model[lowest_id(pend_model & en_model)] = 1'b0;
                @(negedge clk_i);
                check_value("irq_o", data_t'(|(pend_model & en_model)), data_t'(irq_o));
            end
        end
        apb_read(PLIC_BASE + addr_t'(REG_CLAIM), rd, err, cyc);
        check_value("claim id", '0, rd);
        end_test("claim order");

        $display("tests passed %0d failed %0d, errors %0d", pass_count, fail_count, err_count);
        if (fail_count == 0 && err_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule : tb_soc_top

// File: source/apb_xbar.sv
// apb crossbar: address decode, slave selects, response mux and decode error slave

`timescale 1ns/10ps

module apb_xbar import soc_pkg::*; #(
    parameter int unsigned MEM_WORDS = 256
) (
    input  logic  clk_i,
    input  logic  arst_n_i,

    // from the master
    input  logic  psel_i,
    input  logic  penable_i,
    input  addr_t paddr_i,

    // slave selects
    output logic  mem_psel_o,
    output logic  plic_psel_o,

    // memory response
    input  data_t mem_prdata_i,
    input  logic  mem_pready_i,
    input  logic  mem_pslverr_i,

    // plic response
    input  data_t plic_prdata_i,
    input  logic  plic_pready_i,
    input  logic  plic_pslverr_i,

    // back to the master
    output data_t prdata_o,
    output logic  pready_o,
    output logic  pslverr_o
);

    localparam addr_t MEM_SPAN = addr_t'(MEM_WORDS * STRB_WIDTH);   // memory window in bytes

    slave_sel_e sel_d;   // decode of the live address
    slave_sel_e sel_q;   // decode held from setup

    ////////////////////////////////////////////////////////////
    // address decode
    ////////////////////////////////////////////////////////////

    // offset compare, unsigned wrap keeps addresses below the base out
    always_comb begin
        if ((paddr_i - MEM_BASE) < MEM_SPAN) begin
            sel_d = SLV_MEM;
        end else if ((paddr_i - PLIC_BASE) < PLIC_SPAN) begin
            sel_d = SLV_PLIC;
        end else begin
            sel_d = SLV_NONE;   // nothing mapped here
        end
    end

    assign mem_psel_o  = psel_i && (sel_d == SLV_MEM);
    assign plic_psel_o = psel_i && (sel_d == SLV_PLIC);

    // latch decode in the setup cycle
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            sel_q <= SLV_NONE;
        end else if (psel_i && !penable_i) begin
            sel_q <= sel_d;
        end
    end

    ////////////////////////////////////////////////////////////
    // response mux
    ////////////////////////////////////////////////////////////

    always_comb begin
        prdata_o  = '0;   // quiet bus outside the access phase
        pready_o  = 1'b0;
        pslverr_o = 1'b0;
        if (psel_i && penable_i) begin
            unique case (sel_q)
                SLV_MEM: begin
                    prdata_o  = mem_prdata_i;
                    pready_o  = mem_pready_i;
                    pslverr_o = mem_pslverr_i;
                end
                SLV_PLIC: begin
                    prdata_o  = plic_prdata_i;
                    pready_o  = plic_pready_i;
                    pslverr_o = plic_pslverr_i;
                end
                default: begin
                    pready_o  = 1'b1;   // decode error, done at once
                    pslverr_o = 1'b1;
                end
            endcase
        end
    end

endmodule : apb_xbar

// File: source/main_memory.sv
// apb main memory: strobed word writes, registered reads with one wait state

`timescale 1ns/10ps

module main_memory import soc_pkg::*; #(
    parameter int unsigned MEM_WORDS = 256
) (
    input  logic  clk_i,
    input  logic  arst_n_i,

    // apb slave port
    input  logic  psel_i,
    input  logic  penable_i,
    input  logic  pwrite_i,
    input  addr_t paddr_i,
    input  data_t pwdata_i,
    input  strb_t pstrb_i,
    output data_t prdata_o,
    output logic  pready_o,
    output logic  pslverr_o
);

    localparam int unsigned OFF_W = $clog2(STRB_WIDTH);   // byte offset bits
    localparam int unsigned IDX_W = $clog2(MEM_WORDS);    // word index bits

    data_t             mem_q [MEM_WORDS];   // storage array
    data_t             rdata_q;             // registered read port
    logic              rd_wait_q;           // read wait state done
    logic [IDX_W-1:0]  word_idx;
    logic              wr_en;
    logic              rd_en;

    assign word_idx = paddr_i[OFF_W +: IDX_W];   // upper bits already decoded

    assign wr_en = psel_i && penable_i && pwrite_i;
    assign rd_en = psel_i && penable_i && !pwrite_i && !rd_wait_q;   // first read cycle

    ////////////////////////////////////////////////////////////
    // array access
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (wr_en) begin
            for (int b = 0; b < STRB_WIDTH; b++) begin
                if (pstrb_i[b]) begin
                    mem_q[word_idx][8*b +: 8] <= pwdata_i[8*b +: 8];   // lane merge
                end
            end
        end
        if (rd_en) begin
            rdata_q <= mem_q[word_idx];   // block ram style read
        end
    end

    // wait state flag, high for the second read access cycle only
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rd_wait_q <= 1'b0;
        end else begin
            rd_wait_q <= rd_en;
        end
    end

    ////////////////////////////////////////////////////////////
    // response
    ////////////////////////////////////////////////////////////

    assign pready_o  = psel_i && penable_i && (pwrite_i || rd_wait_q);   // writes done at once
    assign prdata_o  = rd_wait_q ? rdata_q : '0;
    assign pslverr_o = 1'b0;   // every word in the window is backed

endmodule : main_memory

// File: source/plic_lite.sv
// reduced plic: pending and enable registers, claim logic, external interrupt line

`timescale 1ns/10ps

module plic_lite import soc_pkg::*; #(
    parameter int unsigned NUM_SRC = 8
) (
    input  logic               clk_i,
    input  logic               arst_n_i,

    // apb slave port
    input  logic               psel_i,
    input  logic               penable_i,
    input  logic               pwrite_i,
    input  addr_t              paddr_i,
    input  data_t              pwdata_i,
    output data_t              prdata_o,
    output logic               pready_o,
    output logic               pslverr_o,

    // interrupts
    input  logic [NUM_SRC-1:0] irq_src_i,
    output logic               irq_o
);

    // source 0 is reserved
    localparam logic [NUM_SRC-1:0] SRC_MASK = {{(NUM_SRC-1){1'b1}}, 1'b0};

    logic [NUM_SRC-1:0]    pending_q;
    logic [NUM_SRC-1:0]    enable_q;
    logic [NUM_SRC-1:0]    active;     // pending and enabled
    logic [NUM_SRC-1:0]    claim_oh;   // lowest active source, one hot
    data_t                 claim_id;
    logic [PLIC_OFF_W-1:0] reg_off;
    logic                  acc;
    logic                  claim_rd;
    data_t                 rd_data;
    logic                  bad_off;

    assign acc     = psel_i && penable_i;
    assign reg_off = paddr_i[PLIC_OFF_W-1:0];   // base already matched by the crossbar

    ////////////////////////////////////////////////////////////
    // claim and interrupt
    ////////////////////////////////////////////////////////////

    assign active = pending_q & enable_q;
    assign irq_o  = |active;   // single external target

    // walk downwards so the lowest id wins
    always_comb begin
        claim_id = '0;
        claim_oh = '0;
        for (int i = NUM_SRC - 1; i >= 1; i--) begin
            if (active[i]) begin
                claim_id    = data_t'(i);
                claim_oh    = '0;
                claim_oh[i] = 1'b1;
            end
        end
    end

    assign claim_rd = acc && !pwrite_i && (reg_off == REG_CLAIM);

    ////////////////////////////////////////////////////////////
    // registers
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pending_q <= '0;
            enable_q  <= '0;
        end else begin
            // level sources re-pend while still high
            pending_q <= ((pending_q & ~(claim_rd ? claim_oh : '0)) | irq_src_i) & SRC_MASK;
            if (acc && pwrite_i && (reg_off == REG_ENABLE)) begin
                enable_q <= pwdata_i[NUM_SRC-1:0] & SRC_MASK;
            end
        end
    end

    // read mux and offset check
    always_comb begin
        rd_data = '0;
        bad_off = 1'b0;
        case (reg_off)
            REG_PENDING: rd_data = data_t'(pending_q);   // writes ignored
            REG_ENABLE:  rd_data = data_t'(enable_q);
            REG_CLAIM:   rd_data = claim_id;             // 0 when nothing to claim
            default:     bad_off = 1'b1;
        endcase
    end

    assign pready_o  = acc;   // no wait states
    assign pslverr_o = acc && bad_off;
    assign prdata_o  = (acc && !pwrite_i) ? rd_data : '0;

endmodule : plic_lite

// File: source/soc_pkg.sv
// shared bus widths, address map, plic register offsets and decode types

package soc_pkg;

    ////////////////////////////////////////////////////////////
    // bus widths
    ////////////////////////////////////////////////////////////

    localparam int unsigned ADDR_WIDTH = 32;
    localparam int unsigned DATA_WIDTH = 32;
    localparam int unsigned STRB_WIDTH = DATA_WIDTH / 8;   // one strobe per byte lane

    typedef logic [ADDR_WIDTH-1:0] addr_t;
    typedef logic [DATA_WIDTH-1:0] data_t;
    typedef logic [STRB_WIDTH-1:0] strb_t;

    ////////////////////////////////////////////////////////////
    // address map
    ////////////////////////////////////////////////////////////

    localparam addr_t MEM_BASE  = 32'h0000_0000;   // main memory, size set by MEM_WORDS
    localparam addr_t PLIC_BASE = 32'h0C00_0000;
    localparam addr_t PLIC_SPAN = 32'h0000_1000;   // 4 KiB window

    // offset bits inside the plic window
    localparam int unsigned PLIC_OFF_W = $clog2(PLIC_SPAN);

    // plic word offsets
    typedef enum logic [PLIC_OFF_W-1:0] {
        REG_PENDING = 'h000,   // read only, level latched
        REG_ENABLE  = 'h004,   // read/write mask
        REG_CLAIM   = 'h008    // read returns id and clears it
    } plic_reg_e;

    // crossbar decode result
    typedef enum logic [1:0] {
        SLV_MEM,
        SLV_PLIC,
        SLV_NONE   // unmapped, answered by the crossbar
    } slave_sel_e;

endpackage : soc_pkg

// File: source/soc_top.sv
// soc top level: apb crossbar, main memory and plic

`timescale 1ns/10ps

module soc_top import soc_pkg::*; #(
    parameter int unsigned MEM_WORDS = 256,   // memory depth in words
    parameter int unsigned NUM_SRC   = 8      // irq sources, 0 reserved
) (
    input  logic               clk_i,
    input  logic               arst_n_i,

    // external apb master
    input  logic               psel_i,
    input  logic               penable_i,
    input  logic               pwrite_i,
    input  addr_t              paddr_i,
    input  data_t              pwdata_i,
    input  strb_t              pstrb_i,
    output data_t              prdata_o,
    output logic               pready_o,
    output logic               pslverr_o,

    // interrupts
    input  logic [NUM_SRC-1:0] irq_src_i,
    output logic               irq_o   // external interrupt line
);

    ////////////////////////////////////////////////////////////
    // slave side wires
    ////////////////////////////////////////////////////////////

    logic  mem_psel;
    data_t mem_prdata;
    logic  mem_pready;
    logic  mem_pslverr;

    logic  plic_psel;
    data_t plic_prdata;
    logic  plic_pready;
    logic  plic_pslverr;

    apb_xbar #(
        .MEM_WORDS ( MEM_WORDS )
    ) apb_xbar_u (
        .clk_i          ( clk_i        ),
        .arst_n_i       ( arst_n_i     ),
        .psel_i         ( psel_i       ),
        .penable_i      ( penable_i    ),
        .paddr_i        ( paddr_i      ),
        .mem_psel_o     ( mem_psel     ),
        .plic_psel_o    ( plic_psel    ),
        .mem_prdata_i   ( mem_prdata   ),
        .mem_pready_i   ( mem_pready   ),
        .mem_pslverr_i  ( mem_pslverr  ),
        .plic_prdata_i  ( plic_prdata  ),
        .plic_pready_i  ( plic_pready  ),
        .plic_pslverr_i ( plic_pslverr ),
        .prdata_o       ( prdata_o     ),
        .pready_o       ( pready_o     ),
        .pslverr_o      ( pslverr_o    )
    );

    // main memory, request fields straight from the master
    main_memory #(
        .MEM_WORDS ( MEM_WORDS )
    ) main_memory_u (
        .clk_i     ( clk_i       ),
        .arst_n_i  ( arst_n_i    ),
        .psel_i    ( mem_psel    ),
        .penable_i ( penable_i   ),
        .pwrite_i  ( pwrite_i    ),
        .paddr_i   ( paddr_i     ),
        .pwdata_i  ( pwdata_i    ),
        .pstrb_i   ( pstrb_i     ),
        .prdata_o  ( mem_prdata  ),
        .pready_o  ( mem_pready  ),
        .pslverr_o ( mem_pslverr )
    );

    // plic, word registers so no strobes
    plic_lite #(
        .NUM_SRC ( NUM_SRC )
    ) plic_lite_u (
        .clk_i     ( clk_i        ),
        .arst_n_i  ( arst_n_i     ),
        .psel_i    ( plic_psel    ),
        .penable_i ( penable_i    ),
        .pwrite_i  ( pwrite_i     ),
        .paddr_i   ( paddr_i      ),
        .pwdata_i  ( pwdata_i     ),
        .prdata_o  ( plic_prdata  ),
        .pready_o  ( plic_pready  ),
        .pslverr_o ( plic_pslverr ),
        .irq_src_i ( irq_src_i    ),
        .irq_o     ( irq_o        )
    );

endmodule : soc_top

// File: verilog.f
+incdir+bench
source/soc_pkg.sv
source/apb_xbar.sv
source/main_memory.sv
source/plic_lite.sv
source/soc_top.sv
bench/tb_soc_top.sv
